// ==== all.f ====
+incdir+testbench
hw/lcd_pkg.sv
hw/layout_pkg.sv
hw/scan_timing.sv
hw/window_decoder.sv
hw/lcd_panel_driver.sv
testbench/tb_lcd_panel_driver.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the LCD panel driver testbench with Verilator, run it, and check the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f all.f --top-module tb_lcd_panel_driver \
	--Mdir "$BUILD_DIR" -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi

// ==== testbench/probe_table.svh ====
// rows must follow scan order; a row earlier than its predecessor is hit in the next frame
typedef struct packed {
	int                  h;
	int                  v;
	logic                de;
	logic                hsync;
	logic                vsync;
	logic [5:0]          request;
	layout_pkg::window_e win;
	int                  x;
	int                  y;
} probe_t;

localparam int NUM_PROBES = 22;

// columns are h, v, de, hsync, vsync, request vector, window, local x and local y
localparam probe_t PROBES [NUM_PROBES] = '{
	'{0,    0,   1'b0, 1'b0, 1'b0, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{1,    0,   1'b0, 1'b0, 1'b0, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{2,    0,   1'b0, 1'b1, 1'b0, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{500,  1,   1'b0, 1'b1, 1'b0, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{0,    2,   1'b0, 1'b0, 1'b1, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{46,   24,  1'b1, 1'b1, 1'b1, 6'b000001, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{694,  24,  1'b1, 1'b1, 1'b1, 6'b000100, layout_pkg::WIN_TITLE,            0,   0},
	'{46,   25,  1'b1, 1'b1, 1'b1, 6'b000001, layout_pkg::WIN_IR_VIEW,          0,   1},
	'{696,  85,  1'b1, 1'b1, 1'b1, 6'b001000, layout_pkg::WIN_BODY_TEMP_LABEL,  2,   1},
	'{10,   100, 1'b0, 1'b1, 1'b1, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{846,  100, 1'b0, 1'b1, 1'b1, 6'b000000, layout_pkg::WIN_TITLE,            0,   0},
	'{741,  129, 1'b1, 1'b1, 1'b1, 6'b010000, layout_pkg::WIN_HEART_RATE_LABEL, 47,  15},
	'{808,  144, 1'b1, 1'b1, 1'b1, 6'b100000, layout_pkg::WIN_PPM_UNIT,         0,   0},
	'{723,  415, 1'b1, 1'b1, 1'b1, 6'b000010, layout_pkg::WIN_THERMAL_INSET,    5,   7},
	'{685,  503, 1'b1, 1'b1, 1'b1, 6'b000001, layout_pkg::WIN_IR_VIEW,          639, 479},
	'{686,  503, 1'b1, 1'b1, 1'b1, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{46,   504, 1'b0, 1'b1, 1'b1, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{1056, 524, 1'b0, 1'b1, 1'b1, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{0,    0,   1'b0, 1'b0, 1'b0, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{700,  1,   1'b0, 1'b1, 1'b0, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{3,    2,   1'b0, 1'b1, 1'b1, 6'b000000, layout_pkg::WIN_IR_VIEW,          0,   0},
	'{46,   24,  1'b1, 1'b1, 1'b1, 6'b000001, layout_pkg::WIN_IR_VIEW,          0,   0}
};

// ==== testbench/tb_lcd_panel_driver.sv ====
// probes cover two frames of the default 800x480 timing; data_in is random every clock
`timescale 1ns/100ps

module tb_lcd_panel_driver;

	localparam int H_LAST  = lcd_pkg::H_TOTAL;
	localparam int V_LAST  = lcd_pkg::V_TOTAL;
	localparam int H_PULSE = lcd_pkg::H_SYNC;
	localparam int V_PULSE = lcd_pkg::V_SYNC;
	localparam int H_START = lcd_pkg::H_SYNC + lcd_pkg::H_BACK;
	localparam int V_START = lcd_pkg::V_SYNC + lcd_pkg::V_BACK;
	localparam int H_END   = H_START + lcd_pkg::H_DISP; // exclusive
	localparam int V_END   = V_START + lcd_pkg::V_DISP;
	localparam int RESET_CYCLES   = 10;
	localparam int TIMEOUT_CYCLES = 2 * (H_LAST + 1) * (V_LAST + 1) + RESET_CYCLES + 1000;

	`include "probe_table.svh"

	logic                               clk = 1'b0;
	logic                               rst_n;
	lcd_pkg::rgb_t                      data_in;
	logic                               lcd_clk;
	logic                               lcd_pwm;
	logic                               lcd_hsync;
	logic                               lcd_vsync;
	logic                               lcd_de;
	logic                               lcd_blank_n;
	lcd_pkg::rgb_t                      lcd_rgb;
	logic [layout_pkg::NUM_WINDOWS-1:0] win_request;
	lcd_pkg::coord_t                    win_x [layout_pkg::NUM_WINDOWS];
	lcd_pkg::coord_t                    win_y [layout_pkg::NUM_WINDOWS];

	int     model_h;
	int     model_v;
	int     cycle_count = 0;
	integer seed;

	lcd_panel_driver lcd_panel_driver_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.data_in     (data_in),
		.lcd_clk     (lcd_clk),
		.lcd_pwm     (lcd_pwm),
		.lcd_hsync   (lcd_hsync),
		.lcd_vsync   (lcd_vsync),
		.lcd_de      (lcd_de),
		.lcd_blank_n (lcd_blank_n),
		.lcd_rgb     (lcd_rgb),
		.win_request (win_request),
		.win_x       (win_x),
		.win_y       (win_y)
	);

	always #2 clk = ~clk; // 4 ns period

	task automatic check(input longint actual, input longint expected, input string what);
		if (actual != expected)
		begin
			$display("ERROR at time %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual,
				expected);
			$display("tests failed");
			$fatal(1, "first mismatch ends the run");
		end
	endtask

	// scan position as the panel timing defines it
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			model_h <= 0;
			model_v <= 0;
		end
		else if (model_h == H_LAST)
		begin
			model_h <= 0;
			model_v <= (model_v == V_LAST) ? 0 : model_v + 1;
		end
		else
			model_h <= model_h + 1;
	end

	always @(posedge clk)
		data_in <= lcd_pkg::rgb_t'($random(seed));

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run stopped before the probe table finished");
			$display("tests failed");
			$fatal(1, "cycle limit reached");
		end
	end

	// pixel clock seen in the middle of each phase
	always @(posedge clk)
	begin
		#1;
		check(lcd_clk, 1'b1, "lcd_clk high phase");
	end

	always @(negedge clk)
	begin
		#1;
		check(lcd_clk, 1'b0, "lcd_clk low phase");
	end

	// every cycle, outputs against the timing and window rules
	always @(negedge clk)
	begin : rule_check
		logic exp_de;
		logic exp_req;
		int   rel_x;
		int   rel_y;
		exp_de = (model_h >= H_START) && (model_h < H_END) && (model_v >= V_START) && (model_v < V_END);
		check(lcd_pwm, rst_n, "lcd_pwm");
		check(lcd_hsync, model_h >= H_PULSE, "lcd_hsync");
		check(lcd_vsync, model_v >= V_PULSE, "lcd_vsync");
		check(lcd_de, exp_de, "lcd_de");
		check(lcd_blank_n, exp_de, "lcd_blank_n");
		check(lcd_rgb, exp_de ? longint'(data_in) : 64'd0, "lcd_rgb");
		for (int k = 0; k < layout_pkg::NUM_WINDOWS; k++)
		begin
			rel_x = model_h - H_START - int'(layout_pkg::WIN_X_START[k]);
			rel_y = model_v - V_START - int'(layout_pkg::WIN_Y_START[k]);
			exp_req = (rel_x >= 0) && (rel_x < int'(layout_pkg::WIN_X_SIZE[k]))
				&& (rel_y >= 0) && (rel_y < int'(layout_pkg::WIN_Y_SIZE[k]));
			check(win_request[k], exp_req, $sformatf("win_request[%0d]", k));
			check(win_x[k], exp_req ? rel_x : 0, $sformatf("win_x[%0d]", k));
			check(win_y[k], exp_req ? rel_y : 0, $sformatf("win_y[%0d]", k));
		end
	end

	initial
	begin
		string where;
		rst_n   = 1'b0;
		data_in = '0;
		seed    = 1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		for (int i = 0; i < NUM_PROBES; i++)
		begin
			do
				@(negedge clk);
			while (!(model_h == PROBES[i].h && model_v == PROBES[i].v));
			where = $sformatf("at h=%0d v=%0d", PROBES[i].h, PROBES[i].v);
			check(lcd_de, PROBES[i].de, {"lcd_de ", where});
			check(lcd_blank_n, PROBES[i].de, {"lcd_blank_n ", where});
			check(lcd_hsync, PROBES[i].hsync, {"lcd_hsync ", where});
			check(lcd_vsync, PROBES[i].vsync, {"lcd_vsync ", where});
			check(lcd_rgb, PROBES[i].de ? longint'(data_in) : 64'd0, {"lcd_rgb ", where});
			check(win_request, PROBES[i].request, {"win_request ", where});
			check(win_x[PROBES[i].win], PROBES[i].x, {"local x ", where});
			check(win_y[PROBES[i].win], PROBES[i].y, {"local y ", where});
		end

		$display("all tests passed");
		$finish;
	end

endmodule

// ==== hw/lcd_panel_driver.sv ====
// 800x480 TFT timing with fixed window table; data_in must be valid in the same clock as lcd_de
`timescale 1ns/100ps

module lcd_panel_driver
#(
	parameter lcd_pkg::hcount_t H_SYNC  = lcd_pkg::H_SYNC,
	parameter lcd_pkg::hcount_t H_BACK  = lcd_pkg::H_BACK,
	parameter lcd_pkg::hcount_t H_DISP  = lcd_pkg::H_DISP,
	parameter lcd_pkg::hcount_t H_TOTAL = lcd_pkg::H_TOTAL,
	parameter lcd_pkg::vcount_t V_SYNC  = lcd_pkg::V_SYNC,
	parameter lcd_pkg::vcount_t V_BACK  = lcd_pkg::V_BACK,
	parameter lcd_pkg::vcount_t V_DISP  = lcd_pkg::V_DISP,
	parameter lcd_pkg::vcount_t V_TOTAL = lcd_pkg::V_TOTAL
)
(
	input  logic                               clk,
	input  logic                               rst_n,
	input  lcd_pkg::rgb_t                      data_in,
	output logic                               lcd_clk,
	output logic                               lcd_pwm,
	output logic                               lcd_hsync,
	output logic                               lcd_vsync,
	output logic                               lcd_de,
	output logic                               lcd_blank_n,
	output lcd_pkg::rgb_t                      lcd_rgb,
	output logic [layout_pkg::NUM_WINDOWS-1:0] win_request,
	output lcd_pkg::coord_t                    win_x [layout_pkg::NUM_WINDOWS],
	output lcd_pkg::coord_t                    win_y [layout_pkg::NUM_WINDOWS]
);

	// window coordinates count from the first active pixel
	localparam lcd_pkg::hcount_t H_OFFSET = H_SYNC + H_BACK;
	localparam lcd_pkg::vcount_t V_OFFSET = V_SYNC + V_BACK;

	lcd_pkg::hcount_t h_count;
	lcd_pkg::vcount_t v_count;

	assign lcd_clk = clk; // panel runs on the pixel clock
	assign lcd_pwm = rst_n; // backlight on once out of reset

	scan_timing
	#(
		.H_SYNC  (H_SYNC),
		.H_BACK  (H_BACK),
		.H_DISP  (H_DISP),
		.H_TOTAL (H_TOTAL),
		.V_SYNC  (V_SYNC),
		.V_BACK  (V_BACK),
		.V_DISP  (V_DISP),
		.V_TOTAL (V_TOTAL)
	)
	scan_timing_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.data_in     (data_in),
		.h_count     (h_count),
		.v_count     (v_count),
		.lcd_hsync   (lcd_hsync),
		.lcd_vsync   (lcd_vsync),
		.lcd_de      (lcd_de),
		.lcd_blank_n (lcd_blank_n),
		.lcd_rgb     (lcd_rgb)
	);

	for (genvar i = 0; i < layout_pkg::NUM_WINDOWS; i++)
	begin : g_window
		localparam layout_pkg::window_e WIN = layout_pkg::window_e'(i);

		window_decoder
		#(
			.X_START  (layout_pkg::WIN_X_START[WIN]),
			.X_SIZE   (layout_pkg::WIN_X_SIZE[WIN]),
			.Y_START  (layout_pkg::WIN_Y_START[WIN]),
			.Y_SIZE   (layout_pkg::WIN_Y_SIZE[WIN]),
			.H_OFFSET (H_OFFSET),
			.V_OFFSET (V_OFFSET)
		)
		window_decoder_inst
		(
			.clk     (clk),
			.rst_n   (rst_n),
			.h_count (h_count),
			.v_count (v_count),
			.request (win_request[i]),
			.local_x (win_x[i]),
			.local_y (win_y[i])
		);
	end

	// every window of the table sits inside the display area
	a_window_in_display: assert property (@(posedge clk) disable iff (!rst_n)
		(|win_request) |-> lcd_de);

endmodule

// ==== hw/window_decoder.sv ====
// one rectangle against the scan position; offsets must equal sync plus back porch of the panel
`timescale 1ns/100ps

module window_decoder
#(
	parameter lcd_pkg::coord_t  X_START  = 11'd0,
	parameter lcd_pkg::coord_t  X_SIZE   = 11'd1,
	parameter lcd_pkg::coord_t  Y_START  = 11'd0,
	parameter lcd_pkg::coord_t  Y_SIZE   = 11'd1,
	parameter lcd_pkg::hcount_t H_OFFSET = lcd_pkg::H_ACTIVE_START,
	parameter lcd_pkg::vcount_t V_OFFSET = lcd_pkg::V_ACTIVE_START
)
(
	input  logic             clk,
	input  logic             rst_n,
	input  lcd_pkg::hcount_t h_count,
	input  lcd_pkg::vcount_t v_count,
	output logic             request,
	output lcd_pkg::coord_t  local_x,
	output lcd_pkg::coord_t  local_y
);

	// one spare bit so the bounds cannot overflow
	typedef logic [lcd_pkg::COORD_W:0] span_t;

	localparam span_t H_LO = span_t'(H_OFFSET) + span_t'(X_START);
	localparam span_t H_HI = H_LO + span_t'(X_SIZE); // exclusive
	localparam span_t V_LO = span_t'(V_OFFSET) + span_t'(Y_START);
	localparam span_t V_HI = V_LO + span_t'(Y_SIZE);

	span_t h_pos;
	span_t v_pos;
	span_t h_rel;
	span_t v_rel;
	logic  in_x;
	logic  in_y;

	assign h_pos = span_t'(h_count);
	assign v_pos = span_t'(v_count);

	assign in_x = (h_pos >= H_LO) && (h_pos < H_HI);
	assign in_y = (v_pos >= V_LO) && (v_pos < V_HI);

	assign request = in_x && in_y;

	// only meaningful inside the rectangle
	assign h_rel = h_pos - H_LO;
	assign v_rel = v_pos - V_LO;

	assign local_x = request ? lcd_pkg::coord_t'(h_rel) : '0;
	assign local_y = request ? lcd_pkg::coord_t'(v_rel) : '0;

	a_local_in_window: assert property (@(posedge clk) disable iff (!rst_n)
		request |-> ((local_x < X_SIZE) && (local_y < Y_SIZE)));

endmodule

// ==== hw/scan_timing.sv ====
// counters wrap inclusively at the totals; all outputs are combinational from the counters
`timescale 1ns/100ps

module scan_timing
#(
	parameter lcd_pkg::hcount_t H_SYNC  = lcd_pkg::H_SYNC,
	parameter lcd_pkg::hcount_t H_BACK  = lcd_pkg::H_BACK,
	parameter lcd_pkg::hcount_t H_DISP  = lcd_pkg::H_DISP,
	parameter lcd_pkg::hcount_t H_TOTAL = lcd_pkg::H_TOTAL,
	parameter lcd_pkg::vcount_t V_SYNC  = lcd_pkg::V_SYNC,
	parameter lcd_pkg::vcount_t V_BACK  = lcd_pkg::V_BACK,
	parameter lcd_pkg::vcount_t V_DISP  = lcd_pkg::V_DISP,
	parameter lcd_pkg::vcount_t V_TOTAL = lcd_pkg::V_TOTAL
)
(
	input  logic             clk,
	input  logic             rst_n,
	input  lcd_pkg::rgb_t    data_in,
	output lcd_pkg::hcount_t h_count,
	output lcd_pkg::vcount_t v_count,
	output logic             lcd_hsync,
	output logic             lcd_vsync,
	output logic             lcd_de,
	output logic             lcd_blank_n,
	output lcd_pkg::rgb_t    lcd_rgb
);

	localparam lcd_pkg::hcount_t H_ACT_START = H_SYNC + H_BACK;
	localparam lcd_pkg::hcount_t H_ACT_END   = H_ACT_START + H_DISP; // exclusive
	localparam lcd_pkg::vcount_t V_ACT_START = V_SYNC + V_BACK;
	localparam lcd_pkg::vcount_t V_ACT_END   = V_ACT_START + V_DISP;

	logic line_end;
	logic frame_end;
	logic h_active;
	logic v_active;

	assign line_end  = (h_count == H_TOTAL);
	assign frame_end = (v_count == V_TOTAL);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			h_count <= '0;
		else if (line_end)
			h_count <= '0;
		else
			h_count <= h_count + 1'b1;
	end

	// steps once per line
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			v_count <= '0;
		else if (line_end)
		begin
			if (frame_end)
				v_count <= '0;
			else
				v_count <= v_count + 1'b1;
		end
	end

	assign lcd_hsync = (h_count >= H_SYNC); // low pulse at the start of each line
	assign lcd_vsync = (v_count >= V_SYNC);

	assign h_active = (h_count >= H_ACT_START) && (h_count < H_ACT_END);
	assign v_active = (v_count >= V_ACT_START) && (v_count < V_ACT_END);

	assign lcd_de      = h_active && v_active;
	assign lcd_blank_n = lcd_de;
	assign lcd_rgb     = lcd_de ? data_in : '0; // black outside the display area

	a_h_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		h_count <= H_TOTAL);

	a_v_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		v_count <= V_TOTAL);

	a_de_inside_sync: assert property (@(posedge clk) disable iff (!rst_n)
		lcd_de |-> (lcd_hsync && lcd_vsync));

endmodule

// ==== hw/layout_pkg.sv ====
// window rectangles are in active-area pixels and must lie inside the 800x480 display
package layout_pkg;

	localparam int NUM_WINDOWS = 6;

	// one entry per screen window, order matches the geometry arrays
	typedef enum logic [2:0]
	{
		WIN_IR_VIEW,
		WIN_THERMAL_INSET,
		WIN_TITLE,
		WIN_BODY_TEMP_LABEL,
		WIN_HEART_RATE_LABEL,
		WIN_PPM_UNIT
	} window_e;

	localparam lcd_pkg::coord_t WIN_X_START [NUM_WINDOWS] = '{
		11'd0,   // ir_view
		11'd672, // thermal_inset
		11'd648, // title
		11'd648, // body_temp_label
		11'd648, // heart_rate_label
		11'd762  // ppm_unit
	};

	localparam lcd_pkg::coord_t WIN_X_SIZE [NUM_WINDOWS] = '{
		11'd640,
		11'd128,
		11'd144,
		11'd48,
		11'd48,
		11'd24
	};

	localparam lcd_pkg::coord_t WIN_Y_START [NUM_WINDOWS] = '{
		11'd0,
		11'd384, // bottom right corner of the screen
		11'd0,
		11'd60,
		11'd90,
		11'd120
	};

	localparam lcd_pkg::coord_t WIN_Y_SIZE [NUM_WINDOWS] = '{
		11'd480,
		11'd96,
		11'd16,  // one text row
		11'd16,
		11'd16,
		11'd136  // unit column spans several rows
	};

endpackage

// ==== hw/lcd_pkg.sv ====
// panel constants assume an 800x480 TFT with inclusive totals, so a line is H_TOTAL+1 clocks
package lcd_pkg;

	localparam int HCOUNT_W = 11;
	localparam int VCOUNT_W = 10;
	localparam int COORD_W  = 11;
	localparam int RGB_W    = 24;

	// horizontal scan position in pixel clocks
	typedef logic [HCOUNT_W-1:0] hcount_t;

	// vertical scan position in lines
	typedef logic [VCOUNT_W-1:0] vcount_t;

	// position inside a screen window, both axes
	typedef logic [COORD_W-1:0] coord_t;

	// 8 bits each of red, green, blue
	typedef logic [RGB_W-1:0] rgb_t;

	// horizontal timing in clocks
	localparam hcount_t H_SYNC  = 11'd2;
	localparam hcount_t H_BACK  = 11'd44;
	localparam hcount_t H_DISP  = 11'd800;
	localparam hcount_t H_TOTAL = 11'd1056; // last count of a line

	// vertical timing in lines
	localparam vcount_t V_SYNC  = 10'd2;
	localparam vcount_t V_BACK  = 10'd22;
	localparam vcount_t V_DISP  = 10'd480;
	localparam vcount_t V_TOTAL = 10'd524; // last line of a frame

	// the active area starts after sync and back porch on both axes
	localparam hcount_t H_ACTIVE_START = H_SYNC + H_BACK;
	localparam vcount_t V_ACTIVE_START = V_SYNC + V_BACK;

	// front porch is whatever remains up to the total
	localparam hcount_t H_FRONT = H_TOTAL + 11'd1 - H_ACTIVE_START - H_DISP;
	localparam vcount_t V_FRONT = V_TOTAL + 10'd1 - V_ACTIVE_START - V_DISP;

endpackage
